// File: verilog/l2Pkg.sv
`default_nettype none

package l2Pkg;

	localparam int tileBits = 128;
	localparam int lineCount = 64;
	localparam int indexBits = 6;
	localparam int lineAddrBits = 28;
	localparam int tagBits = lineAddrBits - indexBits;
	localparam int epochBits = 4;

	typedef logic [tileBits-1:0] tile_t;

	// same opcode set on the requester and the DDR side
	typedef enum logic [4:0]
	{
		OPM_READY = 5'h00,
		OPM_FLUSH = 5'h01,
		OPM_RD_TILE = 5'h0F,
		OPM_WR_TILE = 5'h17
	} memOpm_t;

	typedef enum logic [1:0]
	{
		OK_READY = 2'b00,
		OK_OK = 2'b01,
		OK_HOLD = 2'b10,
		OK_FAULT = 2'b11
	} memOk_t;

	// line number as seen by DDR, or split for the lookup
	typedef union packed
	{
		logic [lineAddrBits-1:0] raw;
		struct packed
		{
			logic [tagBits-1:0] tag;
			logic [indexBits-1:0] index;
		} field;
	} lineAddr_u;

	typedef struct packed
	{
		logic [epochBits-1:0] epoch;
		logic valid;
		logic dirty;
		logic [tagBits-1:0] tag;
	} tagEntry_t;

	typedef struct packed
	{
		logic hit;
		logic dirty;
		logic stale;
		lineAddr_u victimAddr;
		tile_t storedTile;
		lineAddr_u reqAddr;
		memOpm_t opcode;
		tile_t writeData;
	} lookupResult_t;

	// entry.epoch doubles as the current epoch for the compare
	typedef struct packed
	{
		logic enable;
		logic [indexBits-1:0] index;
		tagEntry_t entry;
		tile_t tile;
	} storeCmd_t;

	typedef struct packed
	{
		logic start;
		logic writeBack;
		lineAddr_u victimAddr;
		tile_t victimTile;
		lineAddr_u fillAddr;
	} fetchCmd_t;

	typedef struct packed
	{
		logic done;
		tile_t fillTile;
	} fetchResult_t;

endpackage

`default_nettype wire

// File: verilog/tileLookup.sv
`timescale 1ns/10ps
`default_nettype none

module tileLookup import l2Pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] memAddr,
	input wire memOpm_t memOpm,
	input wire tile_t memDataIn,
	input wire logic advance,
	input wire storeCmd_t store,
	output lookupResult_t result
);

	lineAddr_u nextAddr;
	lineAddr_u reqAddr;
	memOpm_t reqOpm;
	tile_t reqData;

	tagEntry_t tagArray [lineCount];
	tile_t dataArray [lineCount];

	// read register for the line at the request index
	tagEntry_t entryReg;
	tile_t tileReg;

	logic entryStale;
	logic tagMatch;

	// byte offset within the tile is dropped
	assign nextAddr = memAddr[31:4];

	// request register
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// index zero, so the sweep also clears the read register
			reqAddr <= '0;
			reqOpm <= OPM_READY;
		end
		else if (advance)
		begin
			reqAddr <= nextAddr;
			reqOpm <= memOpm;
		end
	end

	always_ff @(posedge clock)
	begin
		if (advance)
			reqData <= memDataIn;
	end

	// store port, shared by sweep, write hits and fills
	always_ff @(posedge clock)
	begin
		if (store.enable)
		begin
			tagArray[store.index] <= store.entry;
			dataArray[store.index] <= store.tile;
		end
	end

	// array read together with the request capture
	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			entryReg <= tagArray[nextAddr.field.index];
			tileReg <= dataArray[nextAddr.field.index];
		end
		else if (store.enable && (store.index == reqAddr.field.index))
		begin
			// keep the read register coherent with the array
			entryReg <= store.entry;
			tileReg <= store.tile;
		end
	end

	// line written before the last flush
	assign entryStale = entryReg.valid && (entryReg.epoch != store.entry.epoch);
	assign tagMatch = entryReg.tag == reqAddr.field.tag;

	always_comb
	begin
		result.stale = entryStale;
		result.hit = entryReg.valid && !entryStale && tagMatch;
		// a dirty line goes back to DDR even when stale
		result.dirty = entryReg.valid && entryReg.dirty;
		result.victimAddr.field.tag = entryReg.tag;
		result.victimAddr.field.index = reqAddr.field.index;
		result.storedTile = tileReg;
		result.reqAddr = reqAddr;
		result.opcode = reqOpm;
		result.writeData = reqData;
	end

endmodule

`default_nettype wire

// File: verilog/ddrFetch.sv
`timescale 1ns/10ps
`default_nettype none

module ddrFetch import l2Pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire fetchCmd_t cmd,
	output fetchResult_t result,
	output logic [31:0] ddrAddr,
	output memOpm_t ddrOpm,
	output tile_t ddrDataOut,
	input wire tile_t ddrDataIn,
	input wire memOk_t ddrOk
);

	typedef enum logic [1:0]
	{
		FETCH_IDLE,
		FETCH_WRITE,
		FETCH_GAP,
		FETCH_READ
	} fetchState_t;

	fetchState_t state;
	logic doneReg;
	tile_t fillReg;
	logic issueStart;
	logic issueRead;
	logic readDone;

	assign issueStart = (state == FETCH_IDLE) && cmd.start;
	// read goes out once the DDR side is back to READY
	assign issueRead = (state == FETCH_GAP) && (ddrOk == OK_READY);
	assign readDone = (state == FETCH_READ) && (ddrOk == OK_OK);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= FETCH_IDLE;
			ddrOpm <= OPM_READY;
			doneReg <= 1'b0;
		end
		else
		begin
			doneReg <= 1'b0;
			case (state)
				FETCH_IDLE:
				begin
					if (cmd.start)
					begin
						if (cmd.writeBack)
						begin
							ddrOpm <= OPM_WR_TILE;
							state <= FETCH_WRITE;
						end
						else
						begin
							ddrOpm <= OPM_RD_TILE;
							state <= FETCH_READ;
						end
					end
				end
				FETCH_WRITE:
				begin
					// opcode stays up through any HOLD
					if (ddrOk == OK_OK)
					begin
						ddrOpm <= OPM_READY;
						state <= FETCH_GAP;
					end
				end
				FETCH_GAP:
				begin
					if (issueRead)
					begin
						ddrOpm <= OPM_RD_TILE;
						state <= FETCH_READ;
					end
				end
				FETCH_READ:
				begin
					if (readDone)
					begin
						ddrOpm <= OPM_READY;
						doneReg <= 1'b1;
						state <= FETCH_IDLE;
					end
				end
				default:
				begin
					ddrOpm <= OPM_READY;
					state <= FETCH_IDLE;
				end
			endcase
		end
	end

	// address and data registers
	always_ff @(posedge clock)
	begin
		if (issueStart)
		begin
			ddrAddr <= {cmd.writeBack ? cmd.victimAddr.raw : cmd.fillAddr.raw, 4'h0};
			ddrDataOut <= cmd.victimTile;
		end
		else if (issueRead)
			ddrAddr <= {cmd.fillAddr.raw, 4'h0};
		if (readDone)
			fillReg <= ddrDataIn;
	end

	assign result.done = doneReg;
	assign result.fillTile = fillReg;

endmodule

`default_nettype wire

// File: verilog/l2Control.sv
`timescale 1ns/10ps
`default_nettype none

module l2Control import l2Pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire lookupResult_t lookup,
	input wire fetchResult_t fetch,
	output fetchCmd_t fetchCmd,
	output storeCmd_t store,
	output logic advance,
	output memOk_t memOk
);

	typedef enum logic [2:0]
	{
		CTRL_INIT,
		CTRL_SWEEP,
		CTRL_IDLE,
		CTRL_FETCH,
		CTRL_RESPOND,
		CTRL_RELEASE
	} ctrlState_t;

	ctrlState_t state;
	ctrlState_t stateNext;
	logic [epochBits-1:0] epoch;
	logic [indexBits-1:0] sweepIndex;
	logic sweepLast;
	logic requestSeen;
	logic isWrite;
	logic isAccess;

	assign sweepLast = sweepIndex == indexBits'(lineCount - 1);
	assign requestSeen = lookup.opcode != OPM_READY;
	assign isWrite = lookup.opcode == OPM_WR_TILE;
	assign isAccess = (lookup.opcode == OPM_RD_TILE) || isWrite;

	always_comb
	begin
		stateNext = state;
		advance = 1'b0;
		memOk = OK_READY;

		// default store is the requested line, dirty for writes
		store.enable = 1'b0;
		store.index = lookup.reqAddr.field.index;
		store.entry.epoch = epoch;
		store.entry.valid = 1'b1;
		store.entry.dirty = isWrite;
		store.entry.tag = lookup.reqAddr.field.tag;
		// a pending write replaces the fill tile
		store.tile = isWrite ? lookup.writeData : fetch.fillTile;

		// fetch fields follow the held request
		fetchCmd.start = 1'b0;
		fetchCmd.writeBack = lookup.dirty;
		fetchCmd.victimAddr = lookup.victimAddr;
		fetchCmd.victimTile = lookup.storedTile;
		fetchCmd.fillAddr = lookup.reqAddr;

		case (state)
			CTRL_INIT:
				stateNext = CTRL_SWEEP;
			CTRL_SWEEP:
			begin
				memOk = OK_HOLD;
				store.enable = 1'b1;
				store.index = sweepIndex;
				store.entry.valid = 1'b0;
				store.entry.dirty = 1'b0;
				store.entry.tag = '0;
				store.tile = '0;
				if (sweepLast)
					stateNext = CTRL_IDLE;
			end
			CTRL_IDLE:
			begin
				if (!requestSeen)
					advance = 1'b1;
				else
				begin
					// decision cycle
					memOk = OK_HOLD;
					if (!isAccess)
						stateNext = CTRL_RESPOND;
					else if (lookup.hit)
					begin
						store.enable = isWrite;
						stateNext = CTRL_RESPOND;
					end
					else
					begin
						fetchCmd.start = 1'b1;
						stateNext = CTRL_FETCH;
					end
				end
			end
			CTRL_FETCH:
			begin
				memOk = OK_HOLD;
				if (fetch.done)
				begin
					store.enable = 1'b1;
					stateNext = CTRL_RESPOND;
				end
			end
			CTRL_RESPOND:
			begin
				// read data comes from the lookup read register
				memOk = OK_OK;
				stateNext = CTRL_RELEASE;
			end
			CTRL_RELEASE:
			begin
				// requester is back to READY here, load that
				advance = 1'b1;
				stateNext = CTRL_IDLE;
			end
			default:
				stateNext = CTRL_INIT;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= CTRL_INIT;
			epoch <= '0;
			sweepIndex <= '0;
		end
		else
		begin
			state <= stateNext;
			if (state == CTRL_SWEEP)
				sweepIndex <= sweepIndex + 1'b1;
			// older lines now miss
			if ((state == CTRL_IDLE) && (lookup.opcode == OPM_FLUSH))
				epoch <= epoch + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/l2TileCache.sv
`timescale 1ns/10ps
`default_nettype none

module l2TileCache import l2Pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] memAddr,
	input wire memOpm_t memOpm,
	input wire tile_t memDataIn,
	output tile_t memDataOut,
	output memOk_t memOk,
	output logic [31:0] ddrAddr,
	output memOpm_t ddrOpm,
	output tile_t ddrDataOut,
	input wire tile_t ddrDataIn,
	input wire memOk_t ddrOk
);

	lookupResult_t lookupResult;
	fetchCmd_t fetchCmd;
	fetchResult_t fetchResult;
	storeCmd_t storeCmd;
	logic advance;

	// read data is the tile held for the current request
	assign memDataOut = lookupResult.storedTile;

	tileLookup lookup_i
	(
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.advance(advance),
		.store(storeCmd),
		.result(lookupResult)
	);

	ddrFetch fetch_i
	(
		.clock(clock),
		.reset(reset),
		.cmd(fetchCmd),
		.result(fetchResult),
		.ddrAddr(ddrAddr),
		.ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut),
		.ddrDataIn(ddrDataIn),
		.ddrOk(ddrOk)
	);

	l2Control control_i
	(
		.clock(clock),
		.reset(reset),
		.lookup(lookupResult),
		.fetch(fetchResult),
		.fetchCmd(fetchCmd),
		.store(storeCmd),
		.advance(advance),
		.memOk(memOk)
	);

endmodule

`default_nettype wire

// File: dv/ddrModel.sv
`timescale 1ns/10ps
`default_nettype none

module ddrModel import l2Pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic [31:0] ddrAddr,
	input wire memOpm_t ddrOpm,
	input wire tile_t ddrDataOut,
	output tile_t ddrDataIn,
	output memOk_t ddrOk,
	output int readCount,
	output int writeCount,
	output tile_t lastWriteTile
);

	typedef enum logic [1:0]
	{
		MODEL_IDLE,
		MODEL_BUSY,
		MODEL_WAIT
	} modelState_t;

	modelState_t state;
	tile_t contents [logic [lineAddrBits-1:0]];
	logic [lineAddrBits-1:0] line;
	memOpm_t opcode;
	int delay;

	// untouched lines read back as their line number, four times over
	function automatic tile_t backgroundTile(input logic [lineAddrBits-1:0] lineNum);
		return {4{{4'h0, lineNum}}};
	endfunction

	initial
	begin
		state = MODEL_IDLE;
		ddrOk = OK_READY;
		ddrDataIn = '0;
		readCount = 0;
		writeCount = 0;
		lastWriteTile = '0;
	end

	always @(posedge clock)
	begin
		if (reset)
		begin
			state <= MODEL_IDLE;
			ddrOk <= OK_READY;
		end
		else
		begin
			case (state)
				MODEL_IDLE:
				begin
					if (ddrOpm != OPM_READY)
					begin
						line <= ddrAddr[31:4];
						opcode <= ddrOpm;
						// back-pressure length varies per transfer
						delay <= 1 + (readCount + writeCount) % 3;
						ddrOk <= OK_HOLD;
						state <= MODEL_BUSY;
					end
				end
				MODEL_BUSY:
				begin
					if (delay > 0)
						delay <= delay - 1;
					else
					begin
						if (opcode == OPM_WR_TILE)
						begin
							contents[line] = ddrDataOut;
							lastWriteTile <= ddrDataOut;
							writeCount <= writeCount + 1;
						end
						else
						begin
							ddrDataIn <= contents.exists(line) ? contents[line] : backgroundTile(line);
							readCount <= readCount + 1;
						end
						ddrOk <= OK_OK;
						state <= MODEL_WAIT;
					end
				end
				default:
				begin
					// requester must drop its opcode before the next transfer
					ddrOk <= OK_READY;
					if (ddrOpm == OPM_READY)
						state <= MODEL_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: dv/l2TileCache_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module l2TileCacheAsserts import l2Pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire memOk_t memOk,
	input wire memOpm_t ddrOpm,
	input wire memOk_t ddrOk
);

	int failCount = 0;

	// OK is a single-cycle pulse
	okPulse: assert property (@(posedge clock) disable iff (reset)
		(memOk == OK_OK) |=> (memOk != OK_OK))
	else
	begin
		failCount++;
		$error("memOk stayed OK for two cycles in a row");
	end

	// DDR back-pressure freezes the opcode
	ddrHold: assert property (@(posedge clock) disable iff (reset)
		(ddrOk == OK_HOLD) |=> $stable(ddrOpm))
	else
	begin
		failCount++;
		$error("ddrOpm changed while ddrOk was HOLD");
	end

	// reset takes effect at the clock edge
	resetIdle: assert property (@(posedge clock)
		reset |=> (memOk == OK_READY) && (ddrOpm == OPM_READY))
	else
	begin
		failCount++;
		$error("memOk or ddrOpm not READY during reset");
	end

endmodule

bind l2TileCache l2TileCacheAsserts asserts_i
(
	.clock(clock),
	.reset(reset),
	.memOk(memOk),
	.ddrOpm(ddrOpm),
	.ddrOk(ddrOk)
);

`default_nettype wire

// File: dv/l2TileCacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module l2TileCacheTb import l2Pkg::*;
();

	typedef struct packed
	{
		memOpm_t op;
		logic [31:0] addr;
		tile_t data;
		tile_t expRead;
		// expected DDR transfers, -1 when not checked
		int reads;
		int writes;
		tile_t wbTile;
	} entry_t;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] memAddr;
	memOpm_t memOpm;
	tile_t memDataIn;
	tile_t memDataOut;
	memOk_t memOk;
	logic [31:0] ddrAddr;
	memOpm_t ddrOpm;
	tile_t ddrDataOut;
	tile_t ddrDataIn;
	memOk_t ddrOk;
	int ddrReads;
	int ddrWrites;
	tile_t lastWriteTile;

	entry_t stimulus [$];
	tile_t shadow [logic [lineAddrBits-1:0]];
	int errorCount = 0;
	int checksDone = 0;
	int watchdogCycles = 0;

	always #5 clock = ~clock;

	l2TileCache dut_i
	(
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.memDataOut(memDataOut),
		.memOk(memOk),
		.ddrAddr(ddrAddr),
		.ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut),
		.ddrDataIn(ddrDataIn),
		.ddrOk(ddrOk)
	);

	ddrModel model_i
	(
		.clock(clock),
		.reset(reset),
		.ddrAddr(ddrAddr),
		.ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut),
		.ddrDataIn(ddrDataIn),
		.ddrOk(ddrOk),
		.readCount(ddrReads),
		.writeCount(ddrWrites),
		.lastWriteTile(lastWriteTile)
	);

	task automatic checkTile(input string name, input tile_t actual, input tile_t expected);
		checksDone++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkOk(input string name, input memOk_t actual, input memOk_t expected);
		checksDone++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic checkOpm(input string name, input memOpm_t actual, input memOpm_t expected);
		checksDone++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic checkValue(input string name, input int actual, input int expected);
		checksDone++;
		if (actual != expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	function automatic tile_t fillPattern(input logic [lineAddrBits-1:0] line);
		return {4{{4'h0, line}}};
	endfunction

	function automatic logic [31:0] addrOf(input logic [tagBits-1:0] tag,
		input logic [indexBits-1:0] index);
		return {tag, index, 4'h0};
	endfunction

	function automatic tile_t randomTile();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// expected read data follows the shadow memory in table order
	function automatic void addEntry(input memOpm_t op, input logic [31:0] addr,
		input tile_t data, input int reads, input int writes, input tile_t wbTile);
		entry_t e;
		logic [lineAddrBits-1:0] line;
		line = addr[31:4];
		e.op = op;
		e.addr = addr;
		e.data = data;
		e.expRead = shadow.exists(line) ? shadow[line] : fillPattern(line);
		e.reads = reads;
		e.writes = writes;
		e.wbTile = wbTile;
		if (op == OPM_WR_TILE)
			shadow[line] = data;
		stimulus.push_back(e);
	endfunction

	task automatic buildStimulus();
		tile_t first;
		tile_t second;
		tile_t third;
		logic [tagBits-1:0] tag;
		logic [indexBits-1:0] index;
		first = randomTile();
		second = randomTile();
		third = randomTile();
		// cold miss, then hit
		addEntry(OPM_RD_TILE, addrOf(1, 3), '0, 1, 0, '0);
		addEntry(OPM_RD_TILE, addrOf(1, 3), '0, 0, 0, '0);
		// write then read back
		addEntry(OPM_WR_TILE, addrOf(2, 5), first, 1, 0, '0);
		addEntry(OPM_RD_TILE, addrOf(2, 5), '0, 0, 0, '0);
		// conflict evicts a dirty line
		addEntry(OPM_WR_TILE, addrOf(4, 7), second, 1, 0, '0);
		addEntry(OPM_RD_TILE, addrOf(5, 7), '0, 1, 1, second);
		addEntry(OPM_RD_TILE, addrOf(4, 7), '0, 1, 0, '0);
		// stale dirty line after flush
		addEntry(OPM_WR_TILE, addrOf(6, 9), third, 1, 0, '0);
		addEntry(OPM_FLUSH, '0, '0, 0, 0, '0);
		addEntry(OPM_RD_TILE, addrOf(7, 9), '0, 1, 1, third);
		addEntry(OPM_RD_TILE, addrOf(1, 3), '0, 1, 0, '0);
		addEntry(OPM_RD_TILE, addrOf(6, 9), '0, 1, 0, '0);
		// random mix over 8 tags and 4 indices
		repeat (24)
		begin
			tag = tagBits'(16 + $urandom_range(7));
			index = indexBits'(20 + $urandom_range(3));
			if ($urandom_range(1) == 1)
				addEntry(OPM_WR_TILE, addrOf(tag, index), randomTile(), -1, -1, '0);
			else
				addEntry(OPM_RD_TILE, addrOf(tag, index), '0, -1, -1, '0);
		end
	endtask

	task automatic applyEntry(input entry_t e, input bit afterReset);
		int cycles;
		int readsBefore;
		int writesBefore;
		readsBefore = ddrReads;
		writesBefore = ddrWrites;
		memOpm = e.op;
		memAddr = e.addr;
		memDataIn = e.data;
		cycles = 0;
		do
		begin
			@(posedge clock);
			#1;
			cycles++;
			if ((memOk === OK_FAULT) || $isunknown(memOk))
				checkOk("memOk", memOk, OK_HOLD);
		end
		while (memOk !== OK_OK);
		if (afterReset)
		begin
			checksDone++;
			if (cycles <= lineCount)
			begin
				errorCount++;
				$display("first request finished after %0d cycles, before the sweep", cycles);
			end
		end
		else if ((e.reads == 0) && (e.writes == 0))
			checkValue("hit latency", cycles, 2);
		if (e.op == OPM_RD_TILE)
			checkTile("memDataOut", memDataOut, e.expRead);
		if (e.reads >= 0)
			checkValue("DDR reads", ddrReads - readsBefore, e.reads);
		if (e.writes >= 0)
			checkValue("DDR writes", ddrWrites - writesBefore, e.writes);
		if (e.writes > 0)
			checkTile("write-back tile", lastWriteTile, e.wbTile);
		memOpm = OPM_READY;
		memAddr = '0;
		memDataIn = '0;
		@(posedge clock);
		#1;
	endtask

	initial
	begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clock);
		$display("timeout: the DUT did not finish within %0d cycles", watchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(67837));
		reset = 1'b1;
		memAddr = '0;
		memOpm = OPM_READY;
		memDataIn = '0;
		buildStimulus();
		watchdogCycles = stimulus.size() * 200 + lineCount + 4;
		repeat (2)
		begin
			@(posedge clock);
			#1;
			checkOk("memOk", memOk, OK_READY);
			checkOpm("ddrOpm", ddrOpm, OPM_READY);
		end
		reset = 1'b0;
		foreach (stimulus[i])
			applyEntry(stimulus[i], i == 0);
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checksDone, errorCount, dut_i.asserts_i.failCount);
		if ((errorCount == 0) && (dut_i.asserts_i.failCount == 0))
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
verilog/l2Pkg.sv
verilog/tileLookup.sv
verilog/ddrFetch.sv
verilog/l2Control.sv
verilog/l2TileCache.sv
dv/ddrModel.sv
dv/l2TileCache_asserts.sv
dv/l2TileCacheTb.sv

// File: Bender.yml
package:
  name: l2TileCache

sources:
  - files:
      - verilog/l2Pkg.sv
      - verilog/tileLookup.sv
      - verilog/ddrFetch.sv
      - verilog/l2Control.sv
      - verilog/l2TileCache.sv
  - target: test
    files:
      - dv/ddrModel.sv
      - dv/l2TileCache_asserts.sv
      - dv/l2TileCacheTb.sv
